// File: design/sw_time_pkg.sv
package sw_time_pkg;

    ////////////////////////////////////////////////////////////////////
    // time field widths
    ////////////////////////////////////////////////////////////////////

    // centiseconds 0..99
    localparam int CS_W  = 7;
    // seconds 0..59
    localparam int SEC_W = 6;
    // minutes 0..59
    localparam int MIN_W = 6;

    ////////////////////////////////////////////////////////////////////
    // last value of each field before it wraps
    ////////////////////////////////////////////////////////////////////

    localparam int CS_LAST  = 99;
    localparam int SEC_LAST = 59;
    localparam int MIN_LAST = 59;

    ////////////////////////////////////////////////////////////////////
    // lap record
    ////////////////////////////////////////////////////////////////////

    // packed as {minutes, seconds, centiseconds}
    // minutes sit in the upper bits, 19 bits in total
    localparam int LAP_W = MIN_W + SEC_W + CS_W;

endpackage

// File: design/sw_ctrl_pkg.sv
package sw_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////
    // button vector layout
    ////////////////////////////////////////////////////////////////////

    localparam int BTN_START = 0;
    localparam int BTN_CLEAR = 1;
    localparam int BTN_LAP   = 2;
    localparam int NUM_BTN   = 3;

    ////////////////////////////////////////////////////////////////////
    // timing defaults, assuming a 100 MHz clk
    ////////////////////////////////////////////////////////////////////

    // 5 ms of stable level before a button change is accepted
    localparam int DEF_DEBOUNCE_CYCLES = 500000;
    // 10 ms per centisecond tick
    localparam int DEF_CLKS_PER_TICK   = 1000000;

    // lap queue sizing
    localparam int DEF_LAP_DEPTH   = 8;
    localparam int DEF_LAP_CREDITS = 4;
    // holds up to 15 outstanding credits
    localparam int CREDIT_W        = 4;

endpackage

// File: design/button_conditioner.sv
module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = sw_ctrl_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_raw,
    output logic press
);

    // counter only has to reach DEBOUNCE_CYCLES-1
    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             sync_q1;
    logic             sync_q2;
    logic [CNT_W-1:0] stable_cnt;
    logic             level;
    logic             level_q;

    ////////////////////////////////////////////////////////////////////
    // two-flop synchronizer
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= btn_raw;
            sync_q2 <= sync_q1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // debounce
    ////////////////////////////////////////////////////////////////////

    // count cycles the synced level differs from the accepted level
    // any return to the accepted level restarts the count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (sync_q2 != level) begin
            if (stable_cnt == CNT_LAST) begin
                // stable long enough, accept the new level
                level      <= sync_q2;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end else begin
            stable_cnt <= '0;
        end
    end

    // rising edge of the debounced level, registered
    // release gives no pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_q <= level;
            press   <= level & ~level_q;
        end
    end

endmodule

// File: design/tick_divider.sv
module tick_divider #(
    parameter int CLKS_PER_TICK = sw_ctrl_pkg::DEF_CLKS_PER_TICK
) (
    input  logic clk,
    input  logic rst_n,
    input  logic running,
    output logic tick
);

    localparam int PH_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(CLKS_PER_TICK - 1);

    logic [PH_W-1:0] phase;

    // phase held at zero while stopped
    // so every start begins a full tick period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
            tick  <= 1'b0;
        end else if (!running) begin
            phase <= '0;
            tick  <= 1'b0;
        end else if (phase == PH_LAST) begin
            // wrap, one-cycle tick
            phase <= '0;
            tick  <= 1'b1;
        end else begin
            phase <= phase + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// File: design/stopwatch_counter.sv
module stopwatch_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_pulse,
    input  logic                        clear_pulse,
    input  logic                        tick,
    output logic                        running,
    output logic [sw_time_pkg::CS_W-1:0]  centiseconds,
    output logic [sw_time_pkg::SEC_W-1:0] seconds,
    output logic [sw_time_pkg::MIN_W-1:0] minutes
);

    import sw_time_pkg::*;

    logic cs_at_last;
    logic sec_at_last;
    logic min_at_last;
    logic advance;

    ////////////////////////////////////////////////////////////////////
    // run/stop state
    ////////////////////////////////////////////////////////////////////

    // clear wins over start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else if (clear_pulse) begin
            running <= 1'b0;
        end else if (start_pulse) begin
            // toggle run/stop
            running <= ~running;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // carry detection
    ////////////////////////////////////////////////////////////////////

    assign cs_at_last  = (centiseconds == CS_W'(CS_LAST));
    assign sec_at_last = (seconds == SEC_W'(SEC_LAST));
    assign min_at_last = (minutes == MIN_W'(MIN_LAST));

    // one centisecond step per tick while running
    assign advance = running & tick;

    ////////////////////////////////////////////////////////////////////
    // cascaded time counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            centiseconds <= '0;
            seconds      <= '0;
            minutes      <= '0;
        end else if (clear_pulse) begin
            // clear zeroes the time whether running or not
            centiseconds <= '0;
            seconds      <= '0;
            minutes      <= '0;
        end else if (advance) begin
            if (cs_at_last) begin
                centiseconds <= '0;
                // carry into seconds
                if (sec_at_last) begin
                    seconds <= '0;
                    // carry into minutes, 59:59.99 wraps to zero
                    if (min_at_last) begin
                        minutes <= '0;
                    end else begin
                        minutes <= minutes + 1'b1;
                    end
                end else begin
                    seconds <= seconds + 1'b1;
                end
            end else begin
                centiseconds <= centiseconds + 1'b1;
            end
        end
    end

endmodule

// File: design/lap_queue.sv
module lap_queue #(
    parameter int LAP_DEPTH   = sw_ctrl_pkg::DEF_LAP_DEPTH,
    parameter int LAP_CREDITS = sw_ctrl_pkg::DEF_LAP_CREDITS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          lap_pulse,
    input  logic [sw_time_pkg::CS_W-1:0]  centiseconds,
    input  logic [sw_time_pkg::SEC_W-1:0] seconds,
    input  logic [sw_time_pkg::MIN_W-1:0] minutes,
    input  logic                          lap_credit,
    output logic                          lap_valid,
    output logic [sw_time_pkg::LAP_W-1:0] lap_time,
    output logic                          lap_overflow
);

    import sw_time_pkg::*;
    import sw_ctrl_pkg::*;

    localparam int PTR_W = (LAP_DEPTH > 1) ? $clog2(LAP_DEPTH) : 1;
    localparam int CNT_W = $clog2(LAP_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(LAP_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(LAP_DEPTH);

    logic [LAP_W-1:0]    mem [LAP_DEPTH];
    logic [LAP_W-1:0]    record;
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CREDIT_W-1:0] credit;
    logic                full;
    logic                push;
    logic                pop;

    // minutes in the upper bits
    assign record = {minutes, seconds, centiseconds};

    assign full = (count == CNT_FULL);
    // a lap onto a full queue is dropped
    assign push = lap_pulse & ~full;
    // issue needs both a record and a credit
    assign pop  = (count != '0) && (credit != '0);

    ////////////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////////////

    // captures the time as it stands in the lap_pulse cycle
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= record;
        end
    end

    // pointers wrap at LAP_DEPTH, depth need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // credits and output
    ////////////////////////////////////////////////////////////////////

    // spent per issued record, refilled per returned credit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= CREDIT_W'(LAP_CREDITS);
        end else begin
            case ({pop, lap_credit})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    // one-cycle strobe per issued record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lap_valid <= 1'b0;
        end else begin
            lap_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            lap_time <= mem[rd_ptr];
        end
    end

    // sticky, only rst_n clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lap_overflow <= 1'b0;
        end else if (lap_pulse && full) begin
            lap_overflow <= 1'b1;
        end
    end

endmodule

// File: design/stopwatch_top.sv
module stopwatch_top #(
    parameter int DEBOUNCE_CYCLES = sw_ctrl_pkg::DEF_DEBOUNCE_CYCLES,
    parameter int CLKS_PER_TICK   = sw_ctrl_pkg::DEF_CLKS_PER_TICK,
    parameter int LAP_DEPTH       = sw_ctrl_pkg::DEF_LAP_DEPTH,
    parameter int LAP_CREDITS     = sw_ctrl_pkg::DEF_LAP_CREDITS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [sw_ctrl_pkg::NUM_BTN-1:0] btn,
    input  logic                            lap_credit,
    output logic                            running,
    output logic [sw_time_pkg::CS_W-1:0]    centiseconds,
    output logic [sw_time_pkg::SEC_W-1:0]   seconds,
    output logic [sw_time_pkg::MIN_W-1:0]   minutes,
    output logic                            lap_valid,
    output logic [sw_time_pkg::LAP_W-1:0]   lap_time,
    output logic                            lap_overflow
);

    import sw_ctrl_pkg::*;

    // one-cycle press pulses
    logic start_pulse;
    logic clear_pulse;
    logic lap_pulse;
    // centisecond tick
    logic tick;

    ////////////////////////////////////////////////////////////////////
    // button conditioning
    ////////////////////////////////////////////////////////////////////

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) start_btn_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .btn_raw (btn[BTN_START]),
        .press   (start_pulse)
    );

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) clear_btn_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .btn_raw (btn[BTN_CLEAR]),
        .press   (clear_pulse)
    );

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) lap_btn_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .btn_raw (btn[BTN_LAP]),
        .press   (lap_pulse)
    );

    ////////////////////////////////////////////////////////////////////
    // timebase and time counter
    ////////////////////////////////////////////////////////////////////

    // phase restarts whenever the watch stops
    tick_divider #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) tick_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .running (running),
        .tick    (tick)
    );

    stopwatch_counter counter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_pulse  (start_pulse),
        .clear_pulse  (clear_pulse),
        .tick         (tick),
        .running      (running),
        .centiseconds (centiseconds),
        .seconds      (seconds),
        .minutes      (minutes)
    );

    ////////////////////////////////////////////////////////////////////
    // lap capture
    ////////////////////////////////////////////////////////////////////

    // not flushed by clear
    lap_queue #(
        .LAP_DEPTH   (LAP_DEPTH),
        .LAP_CREDITS (LAP_CREDITS)
    ) lap_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lap_pulse    (lap_pulse),
        .centiseconds (centiseconds),
        .seconds      (seconds),
        .minutes      (minutes),
        .lap_credit   (lap_credit),
        .lap_valid    (lap_valid),
        .lap_time     (lap_time),
        .lap_overflow (lap_overflow)
    );

endmodule

// File: verif/stopwatch_tb.sv
module stopwatch_tb;

    import sw_time_pkg::*;
    import sw_ctrl_pkg::*;

    localparam int DEB     = 3;
    localparam int CPT     = 4;
    localparam int DEPTH   = 4;
    localparam int CREDITS = 2;
    // ticks in a full turn of the dial up to 60:00.00
    localparam int WRAP = (MIN_LAST + 1) * (SEC_LAST + 1) * (CS_LAST + 1);

    logic               clk;
    logic               rst_n;
    logic [NUM_BTN-1:0] btn;
    logic               lap_credit;
    logic               running;
    logic [CS_W-1:0]    centiseconds;
    logic [SEC_W-1:0]   seconds;
    logic [MIN_W-1:0]   minutes;
    logic               lap_valid;
    logic [LAP_W-1:0]   lap_time;
    logic               lap_overflow;

    // reference model
    logic [NUM_BTN-1:0] btn_q;
    int                 press_cd [NUM_BTN];
    logic [NUM_BTN-1:0] m_press;
    logic               m_running;
    int                 m_phase;
    logic               m_tick;
    int                 m_total;
    int                 m_credit;
    int                 m_returned;
    logic               m_valid;
    logic               m_ovf;
    logic               m_push;
    logic               m_pop;
    logic [LAP_W-1:0]   m_lap_time;
    logic [LAP_W-1:0]   exp_q [$];
    // records taken by the consumer so far
    int                 seen_valid;
    int unsigned        lcg_state = 63237;

    stopwatch_top #(
        .DEBOUNCE_CYCLES (DEB),
        .CLKS_PER_TICK   (CPT),
        .LAP_DEPTH       (DEPTH),
        .LAP_CREDITS     (CREDITS)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .btn          (btn),
        .lap_credit   (lap_credit),
        .running      (running),
        .centiseconds (centiseconds),
        .seconds      (seconds),
        .minutes      (minutes),
        .lap_valid    (lap_valid),
        .lap_time     (lap_time),
        .lap_overflow (lap_overflow)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned rand_below(input int unsigned bound);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % bound;
    endfunction

    // tick count to {MM, SS, CC}
    function automatic logic [LAP_W-1:0] to_record(input int total);
        int cs;
        int sec;
        int mins;
        cs   = total % (CS_LAST + 1);
        sec  = (total / (CS_LAST + 1)) % (SEC_LAST + 1);
        mins = (total / ((CS_LAST + 1) * (SEC_LAST + 1))) % (MIN_LAST + 1);
        return {MIN_W'(mins), SEC_W'(sec), CS_W'(cs)};
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("** Error %s", what);
        abort_run();
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp == act) else report_mismatch(name, exp, act);
    endtask

    // clean press held for 6 cycles
    // then the release settles before the next press
    task automatic press(input int idx);
        @(posedge clk);
        btn[idx] <= 1'b1;
        repeat (6) @(posedge clk);
        btn[idx] <= 1'b0;
        repeat (DEB + 4) @(posedge clk);
    endtask

    task automatic return_credit();
        int gap;
        gap = 1 + rand_below(8);
        repeat (gap) @(posedge clk);
        lap_credit <= 1'b1;
        @(posedge clk);
        lap_credit <= 1'b0;
    endtask

    task automatic wait_running(input logic exp);
        int n;
        n = 0;
        while (running !== exp && n < 32) begin
            @(negedge clk);
            n++;
        end
        if (running !== exp) report_problem($sformatf("running never became %0b", exp));
    endtask

    // wait until the model time reaches a given tick count
    task automatic wait_total(input int target);
        int n;
        int limit;
        @(negedge clk);
        limit = ((target - m_total + WRAP) % WRAP) * CPT + 64;
        n = 0;
        while (m_total != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (m_total != target) report_problem($sformatf("time never reached %0d ticks", target));
    endtask

    task automatic wait_issued(input int k);
        int n;
        n = 0;
        while (seen_valid < k && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (seen_valid < k) report_problem($sformatf("lap record %0d never issued", k));
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of press, tick, time and lap timing
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_q      <= '0;
            m_press    <= '0;
            m_running  <= 1'b0;
            m_phase    <= 0;
            m_tick     <= 1'b0;
            m_total    <= 0;
            m_credit   <= CREDITS;
            m_returned <= 0;
            m_valid    <= 1'b0;
            m_ovf      <= 1'b0;
            m_lap_time <= '0;
            seen_valid <= 0;
            exp_q.delete();
            for (int b = 0; b < NUM_BTN; b++) begin
                press_cd[b] <= 0;
            end
        end else begin
            btn_q <= btn;
            // raw rising edge to pulse is DEB+3 cycles
            for (int b = 0; b < NUM_BTN; b++) begin
                if (btn[b] && !btn_q[b]) begin
                    press_cd[b] <= DEB + 2;
                end else if (press_cd[b] != 0) begin
                    press_cd[b] <= press_cd[b] - 1;
                end
                m_press[b] <= (press_cd[b] == 1);
            end
            // clear wins over start
            if (m_press[BTN_CLEAR]) begin
                m_running <= 1'b0;
            end else if (m_press[BTN_START]) begin
                m_running <= !m_running;
            end
            // first tick CPT cycles after running rises
            m_tick  <= m_running && (m_phase == CPT - 1);
            m_phase <= (!m_running || m_phase == CPT - 1) ? 0 : m_phase + 1;
            if (m_press[BTN_CLEAR]) begin
                m_total <= 0;
            end else if (m_tick && m_running) begin
                m_total <= (m_total + 1) % WRAP;
            end
            // lap records, credits and overflow
            m_push = m_press[BTN_LAP] && (exp_q.size() < DEPTH);
            m_pop  = (exp_q.size() != 0) && (m_credit != 0);
            if (m_pop) begin
                m_lap_time <= exp_q.pop_front();
            end
            if (m_push) begin
                exp_q.push_back(to_record(m_total));
            end
            m_ovf      <= m_ovf | (m_press[BTN_LAP] && !m_push);
            m_valid    <= m_pop;
            m_credit   <= m_credit - int'(m_pop) + int'(lap_credit);
            m_returned <= m_returned + int'(lap_credit);
            if (lap_valid) begin
                seen_valid <= seen_valid + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // every output against the model on the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            expect_eq("time", to_record(m_total), {minutes, seconds, centiseconds});
            expect_eq("running", m_running, running);
            expect_eq("lap_valid", m_valid, lap_valid);
            expect_eq("lap_overflow", m_ovf, lap_overflow);
            if (lap_valid) begin
                expect_eq("lap_time", m_lap_time, lap_time);
                assert (seen_valid + 1 <= CREDITS + m_returned)
                    else report_problem("lap_valid fired with no credit left");
            end
        end
    end

    field_limits: assert property (@(posedge clk) disable iff (!rst_n)
        centiseconds <= CS_LAST && seconds <= SEC_LAST && minutes <= MIN_LAST)
        else report_problem("a time field went past its last value");

    overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        lap_overflow |=> lap_overflow)
        else report_problem("lap_overflow dropped without a reset");

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int n;
        int frozen_total;
        clk        = 1'b0;
        rst_n      = 1'b0;
        btn        = '0;
        lap_credit = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // idle after reset
        expect_eq("reset_running", 0, running);
        expect_eq("reset_time", 0, {minutes, seconds, centiseconds});
        expect_eq("reset_lap_valid", 0, lap_valid);
        expect_eq("reset_overflow", 0, lap_overflow);

        // run for a random number of ticks
        press(BTN_START);
        wait_running(1'b1);
        n = 90 + rand_below(150);
        wait_total(n);
        expect_eq("run_time", to_record(n), {minutes, seconds, centiseconds});

        // stop and hold over several tick periods
        press(BTN_START);
        wait_running(1'b0);
        frozen_total = m_total;
        repeat (5 * CPT) @(negedge clk);
        expect_eq("frozen_time", to_record(frozen_total), {minutes, seconds, centiseconds});
        // resume from the frozen time
        press(BTN_START);
        wait_running(1'b1);
        n = frozen_total + 20 + rand_below(60);
        wait_total(n);
        expect_eq("resumed_time", to_record(n), {minutes, seconds, centiseconds});

        // clear while running and again while stopped
        press(BTN_CLEAR);
        wait_running(1'b0);
        expect_eq("clear_run_time", 0, {minutes, seconds, centiseconds});
        press(BTN_START);
        wait_total(30);
        press(BTN_START);
        wait_running(1'b0);
        press(BTN_CLEAR);
        expect_eq("clear_stop_running", 0, running);
        expect_eq("clear_stop_time", 0, {minutes, seconds, centiseconds});

        // long run through 59:59.99
        press(BTN_START);
        wait_total(WRAP - 1);
        expect_eq("last_time", {MIN_W'(MIN_LAST), SEC_W'(SEC_LAST), CS_W'(CS_LAST)},
                  {minutes, seconds, centiseconds});
        wait_total(0);
        expect_eq("wrap_time", 0, {minutes, seconds, centiseconds});

        // five laps against two initial credits
        repeat (5) begin
            wait_total((m_total + 1 + rand_below(20)) % WRAP);
            press(BTN_LAP);
        end
        wait_issued(2);
        repeat (4 * CPT) @(negedge clk);
        expect_eq("withheld", 2, seen_valid);
        for (int k = 3; k <= 5; k++) begin
            return_credit();
            wait_issued(k);
        end
        // return the last two credits
        // credit count back at its reset value
        return_credit();
        return_credit();
        repeat (4) @(negedge clk);

        // seven laps with no credit returned
        // two go out and four fill the queue
        // the seventh is dropped
        for (int k = 1; k <= 7; k++) begin
            wait_total((m_total + 1 + rand_below(10)) % WRAP);
            if (k == 7) begin
                expect_eq("overflow_before", 0, lap_overflow);
            end
            press(BTN_LAP);
        end
        // five records went out in the previous phase
        wait_issued(7);
        expect_eq("overflow_set", 1, lap_overflow);
        expect_eq("overflow_issued", 7, seen_valid);
        // clear leaves the lap queue alone
        press(BTN_CLEAR);
        expect_eq("overflow_after_clear", 1, lap_overflow);
        expect_eq("time_after_clear", 0, {minutes, seconds, centiseconds});

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: sim.f
design/sw_time_pkg.sv
design/sw_ctrl_pkg.sv
design/button_conditioner.sv
design/tick_divider.sv
design/stopwatch_counter.sv
design/lap_queue.sv
design/stopwatch_top.sv
verif/stopwatch_tb.sv
